//--- src.f
hdl/mem_sys_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_way.sv
hdl/banked_mem.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
sim/tb_clk_gen.sv
sim/mem_system_props.sv
sim/mem_system_tb.sv

//--- Bender.yml
package:
  name: mem_system

sources:
  - hdl/mem_sys_pkg.sv
  - hdl/cache_ctrl_pkg.sv
  - hdl/cache_way.sv
  - hdl/banked_mem.sv
  - hdl/cache_ctrl.sv
  - hdl/mem_system.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/mem_system_props.sv
      - sim/mem_system_tb.sv

//--- sim/mem_system_tb.sv
// Memory system testbench with random requests, cache and memory model, and checks
`timescale 1ns/1ps

module mem_system_tb
   import mem_sys_pkg::*;
();

   localparam int INDEX_W  = 8;
   localparam int BANK_LAT = 4;
   localparam int TAG_BITS = ADDR_W - INDEX_W - OFFSET_W;
   localparam int N_REQ    = 400;
   localparam int TIMEOUT  = 100;   // Cycles

   logic              clk;
   logic              arst_n;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [DATA_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   integer seed;
   int     errors;
   int     n_req;
   bit     aborted;

   logic [DATA_W-1:0]   mem_model [2**(ADDR_W-1)];   // Architectural word image
   logic [TAG_BITS-1:0] tag_model [2][2**INDEX_W];
   logic                vld_model [2][2**INDEX_W];
   logic                ptr_model [2**INDEX_W];
   logic [TAG_BITS-1:0] tag_pool  [6];
   logic [INDEX_W-1:0]  idx_pool  [3];

   tb_clk_gen i_clk_gen (.clk(clk), .arst_n(arst_n));

   mem_system #(.INDEX_W(INDEX_W), .BANK_LAT(BANK_LAT)) i_dut (
      .clk       (clk),      .arst_n  (arst_n),
      .addr      (addr),     .data_in (data_in),
      .rd        (rd),       .wr      (wr),
      .data_out  (data_out), .done    (done),
      .stall     (stall),    .cache_hit (cache_hit),
      .err       (err)
   );

   bind mem_system mem_system_props i_props (
      .clk (clk), .arst_n (arst_n), .addr (addr), .rd (rd), .wr (wr),
      .done (done), .stall (stall), .err (err)
   );

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Hit prediction, then line replacement on a miss
   function automatic bit model_access(input logic [ADDR_W-1:0] a);
      logic [TAG_BITS-1:0] t;
      logic [INDEX_W-1:0]  s;
      int                  v;
      t = a[ADDR_W-1 -: TAG_BITS];
      s = a[OFFSET_W +: INDEX_W];
      for (int w = 0; w < 2; w++) begin
         if (vld_model[w][s] && tag_model[w][s] == t) return 1'b1;
      end
      v = !vld_model[0][s] ? 0 : (!vld_model[1][s] ? 1 : int'(ptr_model[s]));
      ptr_model[s]    = ~ptr_model[s];   // Flips on every replacement
      tag_model[v][s] = t;
      vld_model[v][s] = 1'b1;
      return 1'b0;
   endfunction

   task automatic run_request(input bit is_wr, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d);
      int                cycles;
      bit                exp_hit;
      logic [DATA_W-1:0] exp_data;
      exp_data = mem_model[a[ADDR_W-1:1]];
      exp_hit  = a[0] ? 1'b0 : model_access(a);
      check_value("stall", stall, 0);
      addr    = a;
      data_in = d;
      rd      = !is_wr;
      wr      = is_wr;
      cycles  = 0;
      do begin
         @(posedge clk);
         #1;
         rd = 1'b0;
         wr = 1'b0;
         cycles++;
      end while (!done && !err && cycles < TIMEOUT);
      if (!done && !err) begin
         $display("Timeout: no done or err within %0d cycles for address %h", TIMEOUT, a);
         errors++;
         aborted = 1'b1;
      end else if (a[0]) begin
         check_value("err", err, 1);
         check_value("done", done, 0);
         check_value("err latency", cycles, 1);
         check_value("stall", stall, 0);
         @(posedge clk);
         #1;
         check_value("done", done, 0);
         check_value("err", err, 0);
      end else begin
         check_value("err", err, 0);
         check_value("cache_hit", cache_hit, exp_hit);
         if (exp_hit) check_value("hit latency", cycles, 1);
         if (is_wr) begin
            mem_model[a[ADDR_W-1:1]] = d;
         end else begin
            check_value("data_out", data_out, exp_data);
         end
         @(posedge clk);
         #1;
         check_value("done", done, 0);
         check_value("stall", stall, 0);
         if (!is_wr) check_value("data_out held", data_out, exp_data);
      end
   endtask

   initial begin
      int                wait_cnt;
      logic [ADDR_W-1:0] a;
      seed    = 91692;
      errors  = 0;
      n_req   = 0;
      aborted = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      foreach (mem_model[i]) mem_model[i] = '0;
      for (int s = 0; s < 2**INDEX_W; s++) begin
         vld_model[0][s] = 1'b0;
         vld_model[1][s] = 1'b0;
         ptr_model[s]    = 1'b0;
      end
      for (int i = 0; i < 6; i++) tag_pool[i] = TAG_BITS'(i * 5 + 3);
      for (int i = 0; i < 3; i++) idx_pool[i] = INDEX_W'($random(seed));

      wait_cnt = 0;
      while (arst_n !== 1'b1 && wait_cnt < 20) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (arst_n !== 1'b1) begin
         $display("Reset was never released");
         errors++;
         aborted = 1'b1;
      end
      #1;
      check_value("done after reset", done, 0);
      check_value("stall after reset", stall, 0);
      check_value("cache_hit after reset", cache_hit, 0);
      check_value("err after reset", err, 0);

      while (n_req < N_REQ && !aborted) begin
         a[ADDR_W-1 -: TAG_BITS]   = tag_pool[{$random(seed)} % 6];
         a[OFFSET_W +: INDEX_W]    = idx_pool[{$random(seed)} % 3];
         a[BYTE_SEL_W +: WORD_SEL_W] = WORD_SEL_W'({$random(seed)} % WORDS_PER_LINE);
         a[0] = ({$random(seed)} % 100) < 5;   // About 5% misaligned
         run_request({$random(seed)} % 2, a, DATA_W'($random(seed)));
         n_req++;
      end

      $display("Requests run: %0d, errors: %0d", n_req, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- sim/mem_system_props.sv
// Concurrent protocol assertions for the memory system top level
`timescale 1ns/1ps

module mem_system_props
   import mem_sys_pkg::*;
(
   input logic              clk,
   input logic              arst_n,
   input logic [ADDR_W-1:0] addr,
   input logic              rd,
   input logic              wr,
   input logic              done,
   input logic              stall,
   input logic              err
);

   logic strobe_ok;
   logic strobe_odd;

   assign strobe_ok  = (rd || wr) && !stall && !addr[0];
   assign strobe_odd = (rd || wr) && !stall && addr[0];

   a_stall_rise: assert property (@(posedge clk) disable iff (!arst_n) strobe_ok |=> stall)
      else $error("stall not raised after an accepted request");

   // Stall holds until the done cycle
   a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
      stall && !done |=> stall)
      else $error("stall dropped before done");

   a_odd_err: assert property (@(posedge clk) disable iff (!arst_n)
      strobe_odd |=> err && !stall)
      else $error("misaligned request did not give err");

   a_done_err: assert property (@(posedge clk) disable iff (!arst_n) !(done && err))
      else $error("done and err high in the same cycle");

   a_no_strobe: assert property (@(posedge clk) disable iff (!arst_n) stall |-> !(rd || wr))
      else $error("request strobe raised while stall is high");

endmodule

//--- sim/tb_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_PERIOD = 5,
   parameter int RST_CYCLES  = 2
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;   // Released just after the edge
   end

endmodule

//--- hdl/mem_system.sv
// Memory system top with controller, two cache ways and banked main memory
`timescale 1ns/1ps

module mem_system
   import mem_sys_pkg::*;
#(
   parameter int INDEX_W  = ADDR_W - TAG_W - OFFSET_W,
   parameter int BANK_LAT = 4
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [DATA_W-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   localparam int TAG_BITS = ADDR_W - INDEX_W - OFFSET_W;

   logic                  way0_enable, way1_enable;
   logic                  way0_hit, way1_hit;
   logic                  way0_valid, way1_valid;
   logic                  way0_dirty, way1_dirty;
   logic [TAG_BITS-1:0]   way0_tag, way1_tag;
   logic [DATA_W-1:0]     way0_data, way1_data;

   // Shared by both ways
   logic [INDEX_W-1:0]    way_index;
   logic [WORD_SEL_W-1:0] way_offset;
   logic [TAG_BITS-1:0]   way_tag;
   logic [DATA_W-1:0]     way_data;
   logic                  way_comp;
   logic                  way_write;
   logic                  way_valid_in;

   logic [ADDR_W-1:0]     mem_addr;
   logic [DATA_W-1:0]     mem_data_in;
   logic [DATA_W-1:0]     mem_data_out;
   logic                  mem_wr, mem_rd;
   logic                  mem_valid, mem_stall;

   cache_ctrl #(
      .INDEX_W  (INDEX_W),
      .BANK_LAT (BANK_LAT)
   ) i_ctrl (
      .clk          (clk),          .arst_n       (arst_n),
      .addr         (addr),         .data_in      (data_in),
      .rd           (rd),           .wr           (wr),
      .way0_hit     (way0_hit),     .way0_valid   (way0_valid),
      .way0_dirty   (way0_dirty),   .way0_tag     (way0_tag),
      .way0_data    (way0_data),    .way1_hit     (way1_hit),
      .way1_valid   (way1_valid),   .way1_dirty   (way1_dirty),
      .way1_tag     (way1_tag),     .way1_data    (way1_data),
      .mem_data_out (mem_data_out), .mem_valid    (mem_valid),
      .mem_stall    (mem_stall),    .data_out     (data_out),
      .done         (done),         .stall        (stall),
      .cache_hit    (cache_hit),    .err          (err),
      .way0_enable  (way0_enable),  .way1_enable  (way1_enable),
      .way_index    (way_index),    .way_offset   (way_offset),
      .way_tag      (way_tag),      .way_data     (way_data),
      .way_comp     (way_comp),     .way_write    (way_write),
      .way_valid_in (way_valid_in), .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),  .mem_wr       (mem_wr),
      .mem_rd       (mem_rd)
   );

   cache_way #(.INDEX_W(INDEX_W)) i_way0 (
      .clk      (clk),         .arst_n   (arst_n),     .enable  (way0_enable),
      .index    (way_index),   .offset   (way_offset), .tag_in  (way_tag),
      .data_in  (way_data),    .comp     (way_comp),   .write   (way_write),
      .valid_in (way_valid_in), .tag_out (way0_tag),   .data_out (way0_data),
      .hit      (way0_hit),    .valid    (way0_valid), .dirty   (way0_dirty)
   );

   cache_way #(.INDEX_W(INDEX_W)) i_way1 (
      .clk      (clk),         .arst_n   (arst_n),     .enable  (way1_enable),
      .index    (way_index),   .offset   (way_offset), .tag_in  (way_tag),
      .data_in  (way_data),    .comp     (way_comp),   .write   (way_write),
      .valid_in (way_valid_in), .tag_out (way1_tag),   .data_out (way1_data),
      .hit      (way1_hit),    .valid    (way1_valid), .dirty   (way1_dirty)
   );

   banked_mem #(.BANK_LAT(BANK_LAT)) i_mem (
      .clk      (clk),          .arst_n  (arst_n),
      .addr     (mem_addr),     .data_in (mem_data_in),
      .wr       (mem_wr),       .rd      (mem_rd),
      .data_out (mem_data_out), .valid   (mem_valid),
      .stall    (mem_stall)
   );

endmodule

//--- hdl/cache_ctrl.sv
// Cache controller with request capture, miss sequencing, victim choice and replies
`timescale 1ns/1ps

module cache_ctrl
   import mem_sys_pkg::*, cache_ctrl_pkg::*;
#(
   parameter  int INDEX_W  = 8,
   parameter  int BANK_LAT = 4,
   localparam int TAG_BITS = ADDR_W - INDEX_W - OFFSET_W
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [ADDR_W-1:0]     addr,
   input  logic [DATA_W-1:0]     data_in,
   input  logic                  rd,
   input  logic                  wr,
   input  logic                  way0_hit,
   input  logic                  way0_valid,
   input  logic                  way0_dirty,
   input  logic [TAG_BITS-1:0]   way0_tag,
   input  logic [DATA_W-1:0]     way0_data,
   input  logic                  way1_hit,
   input  logic                  way1_valid,
   input  logic                  way1_dirty,
   input  logic [TAG_BITS-1:0]   way1_tag,
   input  logic [DATA_W-1:0]     way1_data,
   input  logic [DATA_W-1:0]     mem_data_out,
   input  logic                  mem_valid,
   input  logic                  mem_stall,
   output logic [DATA_W-1:0]     data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err,
   output logic                  way0_enable,
   output logic                  way1_enable,
   output logic [INDEX_W-1:0]    way_index,
   output logic [WORD_SEL_W-1:0] way_offset,
   output logic [TAG_BITS-1:0]   way_tag,
   output logic [DATA_W-1:0]     way_data,
   output logic                  way_comp,
   output logic                  way_write,
   output logic                  way_valid_in,
   output logic [ADDR_W-1:0]     mem_addr,
   output logic [DATA_W-1:0]     mem_data_in,
   output logic                  mem_wr,
   output logic                  mem_rd
);

   // At most one read per bank and one per latency cycle in flight
   localparam int INFLIGHT_MAX = (BANK_LAT < WORDS_PER_LINE) ? BANK_LAT : WORDS_PER_LINE;
   localparam int INFLIGHT_W   = $clog2(INFLIGHT_MAX + 1);

   ctrl_state_t state;

   logic [ADDR_W-1:0]     req_addr;
   logic [DATA_W-1:0]     req_data;
   logic                  req_wr;
   logic [TAG_BITS-1:0]   req_tag;
   logic [INDEX_W-1:0]    req_index;
   logic [WORD_SEL_W-1:0] req_word;

   logic [2**INDEX_W-1:0] victim_ptr;   // One per set
   logic                  sel_way;
   logic                  vict_way;
   logic                  vict_dirty;
   logic                  hit_any;
   logic                  line_busy;
   logic                  filling;
   logic                  issue_rd;
   logic                  rd_way;
   logic [DATA_W-1:0]     rd_word;
   logic [DATA_W-1:0]     data_q;
   logic [TAG_BITS-1:0]   sel_tag;

   word_cnt_t             iss_cnt;      // Words sent to memory
   word_cnt_t             ret_cnt;      // Fill words returned
   logic [INFLIGHT_W-1:0] inflight;

   assign req_tag   = req_addr[ADDR_W-1 -: TAG_BITS];
   assign req_index = req_addr[OFFSET_W +: INDEX_W];
   assign req_word  = req_addr[BYTE_SEL_W +: WORD_SEL_W];

   assign hit_any    = way0_hit | way1_hit;
   assign vict_way   = !way0_valid ? 1'b0 : (!way1_valid ? 1'b1 : victim_ptr[req_index]);
   assign vict_dirty = vict_way ? (way1_valid & way1_dirty) : (way0_valid & way0_dirty);

   assign filling   = (state == FILL_ISSUE) || (state == FILL_WAIT);
   assign line_busy = (state == WB_WRITE) || filling || (state == REPLY);
   assign issue_rd  = (state == FILL_ISSUE) && !mem_stall;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= IDLE;
         sel_way    <= 1'b0;
         victim_ptr <= '0;
         iss_cnt    <= '0;
         ret_cnt    <= '0;
         inflight   <= '0;
      end else begin
         case (state)
            IDLE, ERR_REPLY: begin
               if (rd || wr) begin
                  state <= (addr[BYTE_SEL_W-1:0] != '0) ? ERR_REPLY : COMPARE;
               end else begin
                  state <= IDLE;
               end
            end
            COMPARE: begin
               if (hit_any) begin
                  state <= IDLE;
               end else begin
                  sel_way               <= vict_way;
                  victim_ptr[req_index] <= ~victim_ptr[req_index];   // Flips on every miss
                  state                 <= vict_dirty ? WB_WRITE : FILL_ISSUE;
               end
            end
            WB_WRITE:   if (!mem_stall && iss_cnt == 2'd3) state <= FILL_ISSUE;
            FILL_ISSUE: if (!mem_stall && iss_cnt == 2'd3) state <= FILL_WAIT;
            FILL_WAIT:  if (mem_valid && inflight == INFLIGHT_W'(1)) state <= REPLY;
            default:    state <= IDLE;
         endcase

         if ((state == WB_WRITE || state == FILL_ISSUE) && !mem_stall) begin
            iss_cnt <= iss_cnt + 1'b1;   // Wraps to 0 after the fourth word
         end
         if (mem_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
         case ({issue_rd, mem_valid})
            2'b10:   inflight <= inflight + 1'b1;
            2'b01:   inflight <= inflight - 1'b1;
            default: inflight <= inflight;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == IDLE || state == ERR_REPLY) && (rd || wr)) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   assign way0_enable  = (state == COMPARE) | (line_busy & ~sel_way);
   assign way1_enable  = (state == COMPARE) | (line_busy & sel_way);
   assign way_index    = req_index;
   assign way_offset   = (state == WB_WRITE) ? iss_cnt : (filling ? ret_cnt : req_word);
   assign way_tag      = req_tag;
   assign way_data     = filling ? mem_data_out : req_data;
   assign way_comp     = (state == COMPARE) || (state == REPLY);
   assign way_write    = way_comp ? req_wr : (filling & mem_valid);
   assign way_valid_in = filling;

   // Write-back address uses the victim tag, fill address the request tag
   assign sel_tag     = sel_way ? way1_tag : way0_tag;
   assign mem_addr    = {(state == WB_WRITE) ? sel_tag : req_tag, req_index, iss_cnt,
                         {BYTE_SEL_W{1'b0}}};
   assign mem_data_in = sel_way ? way1_data : way0_data;
   assign mem_wr      = (state == WB_WRITE);
   assign mem_rd      = (state == FILL_ISSUE);

   assign rd_way  = (state == COMPARE) ? way1_hit : sel_way;
   assign rd_word = rd_way ? way1_data : way0_data;

   assign done      = ((state == COMPARE) && hit_any) || (state == REPLY);
   assign cache_hit = (state == COMPARE) && hit_any;
   assign stall     = (state == COMPARE) || line_busy;
   assign err       = (state == ERR_REPLY);

   always_ff @(posedge clk) begin
      if (done) begin
         data_q <= rd_word;   // Held until the next done
      end
   end

   assign data_out = done ? rd_word : data_q;

endmodule

//--- hdl/banked_mem.sv
// Four-bank main memory with per-bank busy countdown and pipelined reads
`timescale 1ns/1ps

module banked_mem
   import mem_sys_pkg::*;
#(
   parameter int BANK_LAT = 4
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] data_in,
   input  logic              wr,
   input  logic              rd,
   output logic [DATA_W-1:0] data_out,
   output logic              valid,
   output logic              stall
);

   localparam int ROW_W = ADDR_W - OFFSET_W;
   localparam int ROWS  = 2 ** ROW_W;
   localparam int CNT_W = $clog2(BANK_LAT + 1);

   logic [DATA_W-1:0] mem_arr [WORDS_PER_LINE][ROWS];
   logic [CNT_W-1:0]  busy_cnt [WORDS_PER_LINE];

   logic [DATA_W-1:0] pipe_data [BANK_LAT];
   logic [BANK_LAT-1:0] pipe_vld;

   logic [WORD_SEL_W-1:0] bank;
   logic [ROW_W-1:0]      row;
   logic                  busy;
   logic                  take;

   assign bank = addr[BYTE_SEL_W +: WORD_SEL_W];   // Word of the line picks the bank
   assign row  = addr[OFFSET_W +: ROW_W];

   assign busy  = (busy_cnt[bank] != '0);
   assign stall = (rd | wr) & busy;
   assign take  = (rd | wr) & ~busy;

   // Memory contents start at zero
   initial begin
      for (int b = 0; b < WORDS_PER_LINE; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            mem_arr[b][r] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (take && wr) begin
         mem_arr[bank][row] <= data_in;
      end
   end

   // Bank held for BANK_LAT cycles counting the access cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            if (take && (bank == WORD_SEL_W'(b))) begin
               busy_cnt[b] <= CNT_W'(BANK_LAT - 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= take & rd;
         for (int i = 1; i < BANK_LAT; i++) begin
            pipe_vld[i] <= pipe_vld[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_data[0] <= mem_arr[bank][row];
      for (int i = 1; i < BANK_LAT; i++) begin
         pipe_data[i] <= pipe_data[i-1];
      end
   end

   assign data_out = pipe_data[BANK_LAT-1];
   assign valid    = pipe_vld[BANK_LAT-1];   // BANK_LAT cycles after the read is taken

endmodule

//--- hdl/cache_way.sv
// One cache way with tag, valid, dirty and data arrays and its tag compare
`timescale 1ns/1ps

module cache_way
   import mem_sys_pkg::*;
#(
   parameter  int INDEX_W  = 8,
   localparam int TAG_BITS = ADDR_W - INDEX_W - OFFSET_W
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enable,
   input  logic [INDEX_W-1:0]    index,
   input  logic [WORD_SEL_W-1:0] offset,
   input  logic [TAG_BITS-1:0]   tag_in,
   input  logic [DATA_W-1:0]     data_in,
   input  logic                  comp,
   input  logic                  write,
   input  logic                  valid_in,
   output logic [TAG_BITS-1:0]   tag_out,
   output logic [DATA_W-1:0]     data_out,
   output logic                  hit,
   output logic                  valid,
   output logic                  dirty
);

   localparam int SETS = 2 ** INDEX_W;

   logic [TAG_BITS-1:0] tag_arr  [SETS];
   logic [DATA_W-1:0]   data_arr [SETS][WORDS_PER_LINE];
   logic [SETS-1:0]     valid_arr;
   logic [SETS-1:0]     dirty_arr;

   logic cmp_wr;
   logic fill_wr;

   assign tag_out  = tag_arr[index];
   assign data_out = data_arr[index][offset];
   assign valid    = valid_arr[index];
   assign dirty    = dirty_arr[index];

   assign hit = enable & comp & valid & (tag_out == tag_in);

   assign cmp_wr  = hit & write;                  // Write hit
   assign fill_wr = enable & ~comp & write;       // Line refill from memory

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (fill_wr) begin
         valid_arr[index] <= valid_in;
         dirty_arr[index] <= 1'b0;
      end else if (cmp_wr) begin
         dirty_arr[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_arr[index] <= tag_in;
      end
      if (fill_wr || cmp_wr) begin
         data_arr[index][offset] <= data_in;
      end
   end

endmodule

//--- hdl/cache_ctrl_pkg.sv
// Cache controller state encoding and miss sequence word counter type
package cache_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE,       // Waiting for a request
      COMPARE,    // Tag lookup in both ways
      WB_WRITE,   // Dirty victim written back
      FILL_ISSUE, // Line reads sent to the banks
      FILL_WAIT,  // Waiting for the last fill word
      REPLY,      // Miss finished
      ERR_REPLY   // Misaligned address reported
   } ctrl_state_t;

   // Word position within a line
   typedef logic [1:0] word_cnt_t;

endpackage

//--- hdl/mem_sys_pkg.sv
// Address geometry, data width and address field split constants
package mem_sys_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // Default address split is tag 5, index 8, offset 3
   localparam int TAG_W    = 5;
   localparam int OFFSET_W = 3;

   // Words in one cache line, one memory bank per word
   localparam int WORDS_PER_LINE = 4;

   // Offset bits that pick the word within a line
   localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

   // Offset bits below the word select, the byte select
   localparam int BYTE_SEL_W = OFFSET_W - WORD_SEL_W;

endpackage
